// ==== data_mem.f ====
logic/mem_stage_pkg.sv
logic/store_align.sv
logic/byte_bank.sv
logic/load_extend.sv
logic/debug_wb_port.sv
logic/data_mem_top.sv
bench/data_mem_assert.sv
bench/data_mem_top_tb.sv

// ==== Makefile ====
# verilator build of the data memory testbench
TOP := data_mem_top_tb

.PHONY: all compile run clean

all: run

compile: obj_dir/$(TOP)

obj_dir/$(TOP): data_mem.f logic/*.sv bench/*.sv
	verilator --binary --timing --assert --timescale 1ns/1ps \
		--top-module $(TOP) -f data_mem.f --Mdir obj_dir -o $(TOP)

# exit status of the simulation is the result
run: compile
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// ==== bench/data_mem_top_tb.sv ====
`timescale 1ns/1ps

module data_mem_top_tb
    import mem_stage_pkg::*;
();

    localparam int DEPTH_WORDS = 16;
    // cycles any single wait may take
    localparam int TIMEOUT = 20;
    localparam int N_RANDOM = 16;

    // table operations
    localparam logic [1:0] OP_STORE = 2'd0;
    localparam logic [1:0] OP_LOAD = 2'd1;
    localparam logic [1:0] OP_DBG_RD = 2'd2;
    localparam logic [1:0] OP_DBG_WR = 2'd3;

    // one table step with the expected load or debug word in exp
    typedef struct packed {
        logic [1:0]   op;
        mem_addr_t    addr;
        access_size_t size;
        logic         uns;
        word_t        data;
        logic         mis;
        word_t        exp;
    } step_t;

    localparam int N_STEPS = 29;
    localparam step_t STEPS [N_STEPS] = '{
        // word store and load back
        '{OP_STORE,  32'h04, SIZE_WORD, 1'b0, 32'h8421_f00d, 1'b0, 32'h0000_0000},
        '{OP_LOAD,   32'h04, SIZE_WORD, 1'b0, 32'h0000_0000, 1'b0, 32'h8421_f00d},
        // byte and half merged into a word
        '{OP_STORE,  32'h08, SIZE_WORD, 1'b0, 32'h1122_3344, 1'b0, 32'h0000_0000},
        '{OP_STORE,  32'h09, SIZE_BYTE, 1'b0, 32'h0000_00ab, 1'b0, 32'h0000_0000},
        '{OP_STORE,  32'h0a, SIZE_HALF, 1'b0, 32'h0000_beef, 1'b0, 32'h0000_0000},
        '{OP_LOAD,   32'h08, SIZE_WORD, 1'b0, 32'h0000_0000, 1'b0, 32'hbeef_ab44},
        // lb at every offset of 8421f00d
        '{OP_LOAD,   32'h04, SIZE_BYTE, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_000d},
        '{OP_LOAD,   32'h05, SIZE_BYTE, 1'b0, 32'h0000_0000, 1'b0, 32'hffff_fff0},
        '{OP_LOAD,   32'h06, SIZE_BYTE, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0021},
        '{OP_LOAD,   32'h07, SIZE_BYTE, 1'b0, 32'h0000_0000, 1'b0, 32'hffff_ff84},
        // lbu on the negative bytes
        '{OP_LOAD,   32'h05, SIZE_BYTE, 1'b1, 32'h0000_0000, 1'b0, 32'h0000_00f0},
        '{OP_LOAD,   32'h07, SIZE_BYTE, 1'b1, 32'h0000_0000, 1'b0, 32'h0000_0084},
        // lh and lhu on both halves
        '{OP_LOAD,   32'h04, SIZE_HALF, 1'b0, 32'h0000_0000, 1'b0, 32'hffff_f00d},
        '{OP_LOAD,   32'h06, SIZE_HALF, 1'b0, 32'h0000_0000, 1'b0, 32'hffff_8421},
        '{OP_LOAD,   32'h04, SIZE_HALF, 1'b1, 32'h0000_0000, 1'b0, 32'h0000_f00d},
        '{OP_LOAD,   32'h06, SIZE_HALF, 1'b1, 32'h0000_0000, 1'b0, 32'h0000_8421},
        // misaligned stores must not touch the word
        '{OP_STORE,  32'h0c, SIZE_WORD, 1'b0, 32'h5555_aaaa, 1'b0, 32'h0000_0000},
        '{OP_STORE,  32'h0d, SIZE_HALF, 1'b0, 32'h0000_dead, 1'b1, 32'h0000_0000},
        '{OP_STORE,  32'h0e, SIZE_WORD, 1'b0, 32'h1234_5678, 1'b1, 32'h0000_0000},
        '{OP_LOAD,   32'h0c, SIZE_WORD, 1'b0, 32'h0000_0000, 1'b0, 32'h5555_aaaa},
        '{OP_LOAD,   32'h0e, SIZE_WORD, 1'b0, 32'h0000_0000, 1'b1, 32'h0000_0000},
        '{OP_LOAD,   32'h0f, SIZE_HALF, 1'b0, 32'h0000_0000, 1'b1, 32'h0000_0000},
        // negative bytes at offsets 0 and 2
        '{OP_LOAD,   32'h0c, SIZE_BYTE, 1'b0, 32'h0000_0000, 1'b0, 32'hffff_ffaa},
        '{OP_LOAD,   32'h0c, SIZE_BYTE, 1'b1, 32'h0000_0000, 1'b0, 32'h0000_00aa},
        '{OP_LOAD,   32'h0a, SIZE_BYTE, 1'b0, 32'h0000_0000, 1'b0, 32'hffff_ffef},
        '{OP_LOAD,   32'h0a, SIZE_BYTE, 1'b1, 32'h0000_0000, 1'b0, 32'h0000_00ef},
        // debug reads around a write that changes nothing
        '{OP_DBG_RD, 32'h08, SIZE_WORD, 1'b0, 32'h0000_0000, 1'b0, 32'hbeef_ab44},
        '{OP_DBG_WR, 32'h08, SIZE_WORD, 1'b0, 32'h0000_0000, 1'b0, 32'h0000_0000},
        '{OP_DBG_RD, 32'h08, SIZE_WORD, 1'b0, 32'h0000_0000, 1'b0, 32'hbeef_ab44}
    };

    logic         i_clk = 1'b0;
    logic         i_reset;
    logic         i_mem_write;
    logic         i_mem_read;
    logic         i_unsigned;
    mem_addr_t    i_alu_addr;
    access_size_t i_size;
    word_t        i_store_data;
    logic         i_wb_cyc;
    logic         i_wb_stb;
    logic         i_wb_we;
    mem_addr_t    i_wb_adr;
    word_t        o_load_data;
    logic         o_load_valid;
    logic         o_misaligned;
    word_t        o_wb_dat;
    logic         o_wb_ack;

    // reference bytes indexed by byte address modulo the memory size
    byte_t model [DEPTH_WORDS * 4];
    // words with known contents
    logic  written [DEPTH_WORDS];
    int    seed;

    // 100 ns period
    always #50 i_clk = ~i_clk;

    data_mem_top #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) data_mem_top_inst (.*);

    bind data_mem_top data_mem_assert data_mem_assert_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_mem_write  (i_mem_write),
        .i_mem_read   (i_mem_read),
        .i_addr       (i_alu_addr),
        .i_size       (i_size),
        .i_wb_cyc     (i_wb_cyc),
        .i_wb_stb     (i_wb_stb),
        .i_wb_ack     (o_wb_ack),
        .i_load_valid (o_load_valid),
        .i_misaligned (o_misaligned),
        .i_lane_we    (lane_we)
    );

    task automatic stop_with_failure(input string msg);
        $display("%s", msg);
        $display("Testbench failed");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_load_data(input word_t got, input word_t exp, input string what);
        if (got !== exp)
        begin
            stop_with_failure($sformatf("error at %0t: %s load data %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp)
        begin
            stop_with_failure($sformatf("error at %0t: %s is %b, expected %b",
                                        $time, what, got, exp));
        end
    endtask

    task automatic check_dbg_data(input word_t got, input word_t exp, input string what);
        if (got !== exp)
        begin
            stop_with_failure($sformatf("error at %0t: %s debug data %h, expected %h",
                                        $time, what, got, exp));
        end
    endtask

    // half needs an even address, word a four-byte boundary
    function automatic logic is_misaligned(input mem_addr_t addr, input access_size_t size);
        case (size)
            SIZE_BYTE: return 1'b0;
            SIZE_HALF: return addr[0];
            default:   return addr[1:0] != 2'b00;
        endcase
    endfunction

    function automatic void model_store(input mem_addr_t addr, input access_size_t size,
                                        input word_t data);
        int base;
        int n_bytes;
        base = int'(addr % (DEPTH_WORDS * 4));
        case (size)
            SIZE_BYTE: n_bytes = 1;
            SIZE_HALF: n_bytes = 2;
            default:   n_bytes = 4;
        endcase
        if (!is_misaligned(addr, size))
        begin
            // little endian with the low byte at the low address
            for (int i = 0; i < n_bytes; i++)
            begin
                model[base + i] = data[8*i +: 8];
            end
            written[base / 4] = 1'b1;
        end
    endfunction

    function automatic word_t model_word(input mem_addr_t addr);
        int base;
        base = int'(addr % (DEPTH_WORDS * 4)) & ~3;
        return {model[base + 3], model[base + 2], model[base + 1], model[base]};
    endfunction

    // one-cycle write strobe with the flag checked in the next cycle
    task automatic do_store(input mem_addr_t addr, input access_size_t size,
                            input word_t data, input logic exp_mis);
        @(posedge i_clk);
        i_mem_write  <= 1'b1;
        i_alu_addr   <= addr;
        i_size       <= size;
        i_store_data <= data;
        @(posedge i_clk);
        i_mem_write <= 1'b0;
        @(negedge i_clk);
        check_flag(o_misaligned, exp_mis, "store misaligned flag");
        model_store(addr, size, data);
    endtask

    // valid expected on the second rising edge after the strobe edge
    task automatic do_load(input mem_addr_t addr, input access_size_t size,
                           input logic uns, input logic exp_mis, output word_t data);
        int edges;
        @(posedge i_clk);
        i_mem_read <= 1'b1;
        i_alu_addr <= addr;
        i_size     <= size;
        i_unsigned <= uns;
        @(posedge i_clk);
        i_mem_read <= 1'b0;
        edges = 1;
        @(negedge i_clk);
        check_flag(o_misaligned, exp_mis, "load misaligned flag");
        while (!o_load_valid)
        begin
            if (edges >= TIMEOUT)
            begin
                stop_with_failure("timeout: load valid never rose after a read strobe");
            end
            @(negedge i_clk);
            edges++;
        end
        if (edges != 2)
        begin
            stop_with_failure($sformatf("error at %0t: load valid after %0d cycles, expected 2",
                                        $time, edges));
        end
        data = o_load_data;
        @(negedge i_clk);
        check_flag(o_load_valid, 1'b0, "load valid one cycle later");
    endtask

    // single wishbone transfer where the master holds stb until ack
    task automatic do_debug(input logic we, input mem_addr_t addr, output word_t data);
        int edges;
        @(posedge i_clk);
        i_wb_cyc <= 1'b1;
        i_wb_stb <= 1'b1;
        i_wb_we  <= we;
        i_wb_adr <= addr;
        edges = 0;
        @(negedge i_clk);
        while (!o_wb_ack)
        begin
            if (edges >= TIMEOUT)
            begin
                stop_with_failure("timeout: wishbone ack never came");
            end
            @(negedge i_clk);
            edges++;
        end
        if (edges != 2)
        begin
            stop_with_failure($sformatf("error at %0t: ack after %0d cycles, expected 2",
                                        $time, edges));
        end
        data = o_wb_dat;
        @(posedge i_clk);
        i_wb_cyc <= 1'b0;
        i_wb_stb <= 1'b0;
        i_wb_we  <= 1'b0;
        @(negedge i_clk);
        check_flag(o_wb_ack, 1'b0, "wishbone ack one cycle later");
    endtask

    initial
    begin
        word_t     got;
        word_t     wdata;
        mem_addr_t a;
        mem_addr_t b;
        int        edges;

        i_reset      <= 1'b1;
        i_mem_write  <= 1'b0;
        i_mem_read   <= 1'b0;
        i_unsigned   <= 1'b0;
        i_alu_addr   <= '0;
        i_size       <= SIZE_WORD;
        i_store_data <= '0;
        i_wb_cyc     <= 1'b0;
        i_wb_stb     <= 1'b0;
        i_wb_we      <= 1'b0;
        i_wb_adr     <= '0;
        seed = 32'h9af0;
        for (int i = 0; i < DEPTH_WORDS; i++)
        begin
            written[i] = 1'b0;
        end

        // two reset cycles and then all outputs idle
        repeat (2) @(posedge i_clk);
        i_reset <= 1'b0;
        @(negedge i_clk);
        check_flag(o_load_valid, 1'b0, "load valid after reset");
        check_flag(o_misaligned, 1'b0, "misaligned flag after reset");
        check_flag(o_wb_ack, 1'b0, "wishbone ack after reset");
        check_load_data(o_load_data, '0, "reset");
        check_dbg_data(o_wb_dat, '0, "reset");

        for (int i = 0; i < N_STEPS; i++)
        begin
            case (STEPS[i].op)
                OP_STORE: do_store(STEPS[i].addr, STEPS[i].size, STEPS[i].data, STEPS[i].mis);
                OP_LOAD:
                begin
                    do_load(STEPS[i].addr, STEPS[i].size, STEPS[i].uns, STEPS[i].mis, got);
                    check_load_data(got, STEPS[i].exp, $sformatf("table step %0d", i));
                end
                default:
                begin
                    do_debug(STEPS[i].op == OP_DBG_WR, STEPS[i].addr, got);
                    check_dbg_data(got, STEPS[i].exp, $sformatf("table step %0d", i));
                end
            endcase
        end

        // random aligned word traffic
        for (int i = 0; i < N_RANDOM; i++)
        begin
            a = mem_addr_t'(($random(seed) & (DEPTH_WORDS - 1)) * 4);
            wdata = $random(seed);
            do_store(a, SIZE_WORD, wdata, 1'b0);
            b = mem_addr_t'(($random(seed) & (DEPTH_WORDS - 1)) * 4);
            // unknown word so read back the one just stored
            if (!written[b / 4])
            begin
                b = a;
            end
            do_load(b, SIZE_WORD, 1'b0, 1'b0, got);
            check_load_data(got, model_word(b), "random");
        end

        // two loads on consecutive cycles
        @(posedge i_clk);
        i_mem_read <= 1'b1;
        i_alu_addr <= 32'h04;
        i_size     <= SIZE_WORD;
        i_unsigned <= 1'b0;
        @(posedge i_clk);
        i_alu_addr <= 32'h08;
        @(posedge i_clk);
        i_mem_read <= 1'b0;
        edges = 0;
        @(negedge i_clk);
        while (!o_load_valid)
        begin
            if (edges >= TIMEOUT)
            begin
                stop_with_failure("timeout: back-to-back loads produced no valid");
            end
            @(negedge i_clk);
            edges++;
        end
        check_load_data(o_load_data, model_word(32'h04), "first back-to-back");
        @(negedge i_clk);
        check_flag(o_load_valid, 1'b1, "second back-to-back valid");
        check_load_data(o_load_data, model_word(32'h08), "second back-to-back");
        @(negedge i_clk);
        check_flag(o_load_valid, 1'b0, "valid after back-to-back pair");

        $display("Testbench passed");
        $finish;
    end

endmodule

// ==== bench/data_mem_assert.sv ====
`timescale 1ns/1ps

module data_mem_assert
    import mem_stage_pkg::*;
(
    input logic         i_clk,
    input logic         i_reset,
    input logic         i_mem_write,
    input logic         i_mem_read,
    input mem_addr_t    i_addr,
    input access_size_t i_size,
    input logic         i_wb_cyc,
    input logic         i_wb_stb,
    input logic         i_wb_ack,
    input logic         i_load_valid,
    input logic         i_misaligned,
    input lane_en_t     i_lane_we
);

    // half on an odd address or word off a four-byte boundary
    logic bad_align;

    assign bad_align = (i_size == SIZE_BYTE) ? 1'b0 :
                       (i_size == SIZE_HALF) ? i_addr[0] : (i_addr[1:0] != 2'b00);

    // ack is a one-cycle pulse
    a_ack_pulse: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_ack |-> !$past(i_wb_ack))
        else $error("wishbone ack high two cycles in a row");

    // ack only while a transfer is requested
    a_ack_after_stb: assert property (@(posedge i_clk) disable iff (i_reset)
        i_wb_ack |-> $past(i_wb_cyc && i_wb_stb))
        else $error("wishbone ack without a preceding strobe");

    // valid exactly two edges after the read strobe
    a_load_latency: assert property (@(posedge i_clk) disable iff (i_reset)
        i_load_valid == $past(i_mem_read, 2))
        else $error("load valid not two cycles after the read strobe");

    // misaligned store writes no lane and is flagged one cycle later
    a_no_misaligned_write: assert property (@(posedge i_clk) disable iff (i_reset)
        $past(i_mem_write && bad_align) |-> (i_misaligned && ($past(i_lane_we) == '0)))
        else $error("lane write or missing flag on a misaligned store");

endmodule

// ==== logic/data_mem_top.sv ====
`timescale 1ns/1ps

module data_mem_top
    import mem_stage_pkg::*;
#(
    parameter int DEPTH_WORDS = 16
)
(
    input  logic         i_clk,
    input  logic         i_reset,
    // pipeline side
    input  logic         i_mem_write,
    input  logic         i_mem_read,
    input  logic         i_unsigned,
    input  mem_addr_t    i_alu_addr,
    input  access_size_t i_size,
    input  word_t        i_store_data,
    // wishbone debug side
    input  logic         i_wb_cyc,
    input  logic         i_wb_stb,
    input  logic         i_wb_we,
    input  mem_addr_t    i_wb_adr,
    output word_t        o_load_data,
    output logic         o_load_valid,
    output logic         o_misaligned,
    output word_t        o_wb_dat,
    output logic         o_wb_ack
);

    lane_en_t  lane_we;
    word_t     lane_data;
    // pipeline read bytes, lane n in bits 8n+7:8n
    word_t     lane_bytes;
    // debug read bytes, same packing
    word_t     dbg_word;
    mem_addr_t dbg_index;
    // word index of the pipeline access
    mem_addr_t pipe_index;

    assign pipe_index = {2'b00, i_alu_addr[31:2]};

    // stores into lanes, misalignment flag
    store_align store_align_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_mem_write  (i_mem_write),
        .i_mem_read   (i_mem_read),
        .i_addr       (i_alu_addr),
        .i_size       (i_size),
        .i_store_data (i_store_data),
        .o_lane_we    (lane_we),
        .o_lane_data  (lane_data),
        .o_misaligned (o_misaligned)
    );

    // four byte lanes
    for (genvar g = 0; g < N_LANES; g++)
    begin : g_lane
        byte_bank #(
            .DEPTH_WORDS (DEPTH_WORDS)
        ) byte_bank_inst (
            .i_clk       (i_clk),
            .i_we        (lane_we[g]),
            .i_wr_index  (pipe_index),
            .i_rd_index  (pipe_index),
            .i_wr_byte   (lane_data[8*g +: 8]),
            .i_dbg_index (dbg_index),
            .o_rd_byte   (lane_bytes[8*g +: 8]),
            .o_dbg_byte  (dbg_word[8*g +: 8])
        );
    end

    // select and extend the loaded lanes
    load_extend #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) load_extend_inst (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_mem_read   (i_mem_read),
        .i_addr       (i_alu_addr),
        .i_size       (i_size),
        .i_unsigned   (i_unsigned),
        .i_misaligned (o_misaligned),
        .i_lane_bytes (lane_bytes),
        .o_load_data  (o_load_data),
        .o_load_valid (o_load_valid)
    );

    // debug host reads over wishbone
    debug_wb_port #(
        .DEPTH_WORDS (DEPTH_WORDS)
    ) debug_wb_port_inst (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_wb_cyc    (i_wb_cyc),
        .i_wb_stb    (i_wb_stb),
        .i_wb_we     (i_wb_we),
        .i_wb_adr    (i_wb_adr),
        .i_dbg_word  (dbg_word),
        .o_dbg_index (dbg_index),
        .o_wb_dat    (o_wb_dat),
        .o_wb_ack    (o_wb_ack)
    );

endmodule

// ==== logic/debug_wb_port.sv ====
`timescale 1ns/1ps

module debug_wb_port
    import mem_stage_pkg::*;
#(
    parameter int DEPTH_WORDS = 16
)
(
    input  logic      i_clk,
    input  logic      i_reset,
    input  logic      i_wb_cyc,
    input  logic      i_wb_stb,
    input  logic      i_wb_we,
    input  mem_addr_t i_wb_adr,
    input  word_t     i_dbg_word,
    output mem_addr_t o_dbg_index,
    output word_t     o_wb_dat,
    output logic      o_wb_ack
);

    // word index wraps modulo depth
    localparam mem_addr_t IDX_MASK = mem_addr_t'(DEPTH_WORDS - 1);

    // one transfer open, held until stb drops
    logic busy;
    // bank read in flight, ack on the next edge
    logic pending;
    // write transfers return zero
    logic we_q;
    logic start;

    // new transfer only when idle
    assign start = i_wb_cyc && i_wb_stb && !busy;

    // index follows the bus address directly
    // the bank registers it on the first stb edge
    assign o_dbg_index = (i_wb_adr >> 2) & IDX_MASK;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            busy     <= 1'b0;
            pending  <= 1'b0;
            we_q     <= 1'b0;
            o_wb_ack <= 1'b0;
            o_wb_dat <= '0;
        end
        else
        begin
            // ack is a single cycle pulse
            o_wb_ack <= 1'b0;
            if (start)
            begin
                busy    <= 1'b1;
                pending <= 1'b1;
                we_q    <= i_wb_we;
            end
            else if (pending)
            begin
                // bank word is valid now
                pending  <= 1'b0;
                o_wb_ack <= 1'b1;
                o_wb_dat <= we_q ? '0 : i_dbg_word;
            end
            else if (busy && !(i_wb_cyc && i_wb_stb))
            begin
                // master released the bus
                busy <= 1'b0;
            end
        end
    end

endmodule

// ==== logic/load_extend.sv ====
`timescale 1ns/1ps

module load_extend
    import mem_stage_pkg::*;
#(
    parameter int DEPTH_WORDS = 16
)
(
    input  logic         i_clk,
    input  logic         i_reset,
    input  logic         i_mem_read,
    input  mem_addr_t    i_addr,
    input  access_size_t i_size,
    input  logic         i_unsigned,
    input  logic         i_misaligned,
    input  word_t        i_lane_bytes,
    output word_t        o_load_data,
    output logic         o_load_valid
);

    // banks wrap the index with a bit slice, so depth must be a power of two
    if ((1 << $clog2(DEPTH_WORDS)) != DEPTH_WORDS)
    begin : g_depth_check
        $error("DEPTH_WORDS must be a power of two");
    end

    // strobe delayed to line up with the bank read registers
    logic         rd_q;
    logic [1:0]   offset_q;
    access_size_t size_q;
    logic         unsigned_q;
    byte_t        sel_byte;
    logic [15:0]  sel_half;
    word_t        extended;

    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            rd_q <= 1'b0;
        end
        else
        begin
            rd_q <= i_mem_read;
        end
    end

    // access attributes for the second stage
    always_ff @(posedge i_clk)
    begin
        offset_q   <= i_addr[1:0];
        size_q     <= i_size;
        unsigned_q <= i_unsigned;
    end

    // pick the addressed byte
    always_comb
    begin
        case (offset_q)
            2'd0:    sel_byte = i_lane_bytes[7:0];
            2'd1:    sel_byte = i_lane_bytes[15:8];
            2'd2:    sel_byte = i_lane_bytes[23:16];
            default: sel_byte = i_lane_bytes[31:24];
        endcase
    end

    // half from the low or high pair of lanes
    assign sel_half = offset_q[1] ? i_lane_bytes[31:16] : i_lane_bytes[15:0];

    // sign or zero fill
    always_comb
    begin
        case (size_q)
            SIZE_BYTE: extended = {{24{sel_byte[7] & ~unsigned_q}}, sel_byte};
            SIZE_HALF: extended = {{16{sel_half[15] & ~unsigned_q}}, sel_half};
            default:   extended = i_lane_bytes;
        endcase
    end

    // second stage drives valid two cycles after the strobe
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_load_valid <= 1'b0;
            o_load_data  <= '0;
        end
        else
        begin
            o_load_valid <= rd_q;
            // misaligned flag arrives in this same cycle from the aligner
            if (rd_q)
            begin
                o_load_data <= i_misaligned ? '0 : extended;
            end
        end
    end

endmodule

// ==== logic/byte_bank.sv ====
`timescale 1ns/1ps

module byte_bank
    import mem_stage_pkg::*;
#(
    parameter int DEPTH_WORDS = 16
)
(
    input  logic      i_clk,
    input  logic      i_we,
    input  mem_addr_t i_wr_index,
    input  mem_addr_t i_rd_index,
    input  byte_t     i_wr_byte,
    input  mem_addr_t i_dbg_index,
    output byte_t     o_rd_byte,
    output byte_t     o_dbg_byte
);

    // index bits kept, upper bits wrap modulo depth
    localparam int IDX_W = (DEPTH_WORDS > 1) ? $clog2(DEPTH_WORDS) : 1;

    byte_t mem [DEPTH_WORDS];

    // one write port, rising edge
    always_ff @(posedge i_clk)
    begin
        if (i_we)
        begin
            mem[i_wr_index[IDX_W-1:0]] <= i_wr_byte;
        end
    end

    // both read ports registered every cycle
    // same-cycle write is not seen, old byte comes out
    always_ff @(posedge i_clk)
    begin
        o_rd_byte  <= mem[i_rd_index[IDX_W-1:0]];
        o_dbg_byte <= mem[i_dbg_index[IDX_W-1:0]];
    end

endmodule

// ==== logic/store_align.sv ====
`timescale 1ns/1ps

module store_align
    import mem_stage_pkg::*;
(
    input  logic         i_clk,
    input  logic         i_reset,
    input  logic         i_mem_write,
    input  logic         i_mem_read,
    input  mem_addr_t    i_addr,
    input  access_size_t i_size,
    input  word_t        i_store_data,
    output lane_en_t     o_lane_we,
    output word_t        o_lane_data,
    output logic         o_misaligned
);

    // byte offset inside the word
    logic [1:0] offset;
    logic       misaligned;
    lane_en_t   lane_mask;

    assign offset = i_addr[1:0];

    // half needs an even address, word needs offset zero
    // size code 3 falls into the word rule
    always_comb
    begin
        case (i_size)
            SIZE_BYTE: misaligned = 1'b0;
            SIZE_HALF: misaligned = offset[0];
            default:   misaligned = (offset != 2'b00);
        endcase
    end

    // lanes touched by the access
    always_comb
    begin
        case (i_size)
            SIZE_BYTE: lane_mask = lane_en_t'(4'b0001 << offset);
            SIZE_HALF: lane_mask = offset[1] ? 4'b1100 : 4'b0011;
            default:   lane_mask = 4'b1111;
        endcase
    end

    // copy the low byte or half into every lane
    // the enables pick which copies land
    always_comb
    begin
        case (i_size)
            SIZE_BYTE: o_lane_data = {N_LANES{i_store_data[7:0]}};
            SIZE_HALF: o_lane_data = {2{i_store_data[15:0]}};
            default:   o_lane_data = i_store_data;
        endcase
    end

    // a misaligned store writes nothing at all
    assign o_lane_we = (i_mem_write && !misaligned) ? lane_mask : '0;

    // flag for the cycle after the strobe, lines up with the bank outputs
    always_ff @(posedge i_clk)
    begin
        if (i_reset)
        begin
            o_misaligned <= 1'b0;
        end
        else
        begin
            o_misaligned <= (i_mem_write || i_mem_read) && misaligned;
        end
    end

endmodule

// ==== logic/mem_stage_pkg.sv ====
package mem_stage_pkg;

    // one pipeline data word
    typedef logic [31:0] word_t;

    // one byte lane datum
    typedef logic [7:0] byte_t;

    // byte address from the alu or the debug bus
    // also carries a word index once shifted down
    typedef logic [31:0] mem_addr_t;

    // per-lane write enables, bit n drives lane n
    typedef logic [3:0] lane_en_t;

    // access size as decoded from the load/store opcode
    typedef logic [1:0] access_size_t;

    // lb/lbu/sb
    localparam access_size_t SIZE_BYTE = 2'd0;

    // lh/lhu/sh
    localparam access_size_t SIZE_HALF = 2'd1;

    // lw/sw, code 3 is unused and decoded as word too
    localparam access_size_t SIZE_WORD = 2'd2;

    // byte lanes per word, lane 0 holds address offset 0
    localparam int N_LANES = 4;

endpackage
